/* sources.f */
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_decode.sv
rtl/approx_adder.sv
rtl/barrel_shifter.sv
rtl/alu_result_stage.sv
rtl/alu_top.sv
tests/alu_chk.sv
tests/alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module alu_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so every test reports
./obj_dir/Valu_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* tests/alu_tb.sv */
/*
 * ALU testbench
 * Drives alu_top through strobe, logic, shift and adder tests plus a
 * back-to-back burst; the bound checker judges every result
 */
`include "alu_defs.svh"

module alu_tb;

    localparam int TIMEOUT = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`ALU_WIDTH-1:0] accuracy_control;
    logic [`ALU_WIDTH-1:0] rs1;
    logic [`ALU_WIDTH-1:0] rs2;
    logic [`ALU_WIDTH-1:0] immediate;
    logic                  result_valid;
    logic [`ALU_WIDTH-1:0] result;

    int seed;
    int fails_seen;
    int tests_passed;
    int tests_failed;

    alu_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .opcode           (opcode),
        .funct3           (funct3),
        .funct7           (funct7),
        .accuracy_control (accuracy_control),
        .rs1              (rs1),
        .rs2              (rs2),
        .immediate        (immediate),
        .result_valid     (result_valid),
        .result           (result)
    );

    always #2 clk = ~clk;

    // Sign-extended 12-bit I-type immediate
    function automatic logic [31:0] sext12(input logic [31:0] r);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // Alternate between register and immediate forms
    function automatic logic [6:0] pick_opc(input int k);
        return (k % 2 == 0) ? `OPC_OP : `OPC_OP_IMM;
    endfunction

    // One strobed instruction on the next rising edge
    task automatic drive_op(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                            input logic [31:0] csr, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] imm);
        @(posedge clk);
        in_valid         <= 1'b1;
        opcode           <= opc;
        funct3           <= f3;
        funct7           <= f7;
        accuracy_control <= csr;
        rs1              <= a;
        rs2              <= b;
        immediate        <= imm;
    endtask

    // Drop the strobe and wait for the registered result
    task automatic wait_result(input string name);
        int n;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        n = 0;
        while (!result_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!result_valid) begin
            $display("Timeout in test %s: result_valid never rose", name);
            $display("Test FAILED");
            $finish;
        end
    endtask

    // Rejected instruction leaves result_valid low one cycle later
    task automatic drop_strobe();
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
    endtask

    // Name the running test in the checker's error lines
    task automatic begin_test(input string name);
        dut_i.chk_i.test_name = name;
    endtask

    // Let the checker see the last result before reporting
    task automatic end_test(input string name);
        int n;
        @(negedge clk);
        n = dut_i.chk_i.fail_count - fails_seen;
        if (n == 0) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s: %0d assertion failures", name, n);
            tests_failed++;
        end
        fails_seen = dut_i.chk_i.fail_count;
    endtask

    initial begin
        int n;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        opcode = '0;
        funct3 = '0;
        funct7 = '0;
        accuracy_control = '0;
        rs1 = '0;
        rs2 = '0;
        immediate = '0;
        fails_seen = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed = 32'hf43f;
        void'($urandom(seed));

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // --------------------------------------------------
        // One good op followed by bad opcodes and bad funct7 codes
        // --------------------------------------------------
        begin_test("strobe");
        drive_op(`OPC_OP, `F3_ADDSUB, `F7_BASE, 0, $urandom(), $urandom(), 0);
        wait_result("strobe");
        drive_op(7'b000_0011, `F3_ADDSUB, `F7_BASE, 0, $urandom(), $urandom(), 0);
        drop_strobe();
        drive_op(`OPC_OP, `F3_ADDSUB, 7'h01, 0, $urandom(), $urandom(), 0);
        drop_strobe();
        drive_op(`OPC_OP, `F3_SR, 7'h01, 0, $urandom(), $urandom(), 0);
        drop_strobe();
        drive_op(`OPC_OP_IMM, `F3_SLL, `F7_ALT, 0, $urandom(), 0, $urandom());
        drop_strobe();
        end_test("strobe");

        // Logic and compare ops over funct3 2..7 except SR
        begin_test("logic_compare");
        for (int f = 2; f < 8; f++) begin
            for (int k = 0; k < 6 && f != 5; k++) begin
                drive_op(pick_opc(k), 3'(f), `F7_BASE, 0, $urandom(), $urandom(),
                         sext12($urandom()));
                wait_result("logic_compare");
            end
        end
        end_test("logic_compare");

        // SLL, SRL and SRA in both forms
        begin_test("shifts");
        for (int k = 0; k < 24; k++) begin
            drive_op(pick_opc(k), (k % 3 == 0) ? `F3_SLL : `F3_SR,
                     (k % 3 == 2) ? `F7_ALT : `F7_BASE, 0, $urandom(), $urandom(), $urandom());
            wait_result("shifts");
        end
        end_test("shifts");

        // Exact mode first and then approximate mode with every bit enabled
        begin_test("accurate_arith");
        for (int k = 0; k < 24; k++) begin
            drive_op(pick_opc(k), `F3_ADDSUB, (k % 4 == 0) ? `F7_ALT : `F7_BASE,
                     (k < 12) ? ($urandom() & ~32'h1) : ($urandom() | 32'h7f9),
                     $urandom(), $urandom(), sext12($urandom()));
            wait_result("accurate_arith");
        end
        end_test("accurate_arith");

        // Random error enables with a zero low byte on every third add
        begin_test("approx_arith");
        for (int k = 0; k < 30; k++) begin
            drive_op(pick_opc(k), `F3_ADDSUB, (k % 4 == 0) ? `F7_ALT : `F7_BASE,
                     $urandom() | 32'h1, (k % 3 == 0) ? ($urandom() & 32'hffff_ff00) : $urandom(),
                     $urandom(), sext12($urandom()));
            wait_result("approx_arith");
        end
        end_test("approx_arith");

        // --------------------------------------------------
        // Back-to-back burst of mixed ops including unsupported ones
        // --------------------------------------------------
        begin_test("burst");
        for (int k = 0; k < 40; k++) begin
            drive_op((k % 7 == 0) ? 7'b001_0111 : pick_opc(k / 3), 3'($urandom()),
                     (k % 5 == 0) ? 7'($urandom()) : ((k % 3 == 0) ? `F7_ALT : `F7_BASE),
                     $urandom(), $urandom(), $urandom(), sext12($urandom()));
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        n = 0;
        while (result_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (result_valid) begin
            $display("Timeout in test burst: result_valid never fell");
            $display("Test FAILED");
            $finish;
        end
        end_test("burst");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tests/alu_chk.sv */
/*
 * ALU result checker
 * Bound to alu_top; derives the expected strobe and result from the
 * inputs of the previous cycle and checks them with concurrent assertions
 */
`include "alu_defs.svh"

module alu_chk import alu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic [6:0] opcode,
    input logic [2:0] funct3,
    input logic [6:0] funct7,
    input word_t      accuracy_control,
    input word_t      rs1,
    input word_t      rs2,
    input word_t      immediate,
    input logic       result_valid,
    input word_t      result
);

    localparam int HI = `ALU_WIDTH - `APX_LEN;

    // Failed checks so far
    int fail_count = 0;

    // Name of the test now running as set by the testbench
    string test_name = "none";

    word_t         opb;
    word_t         add_b;
    word_t         exp_exact;
    logic [HI-1:0] hi_sum;
    logic          alt;
    logic          is_sub;
    logic          supported;
    logic          exact_case;

    // --------------------------------------------------
    // Reference rules on the current inputs
    // --------------------------------------------------
    always_comb begin
        opb    = (opcode == `OPC_OP_IMM) ? immediate : rs2;
        alt    = (funct7 == `F7_ALT);
        // SUB exists only in register form
        is_sub = (opcode == `OPC_OP) && (funct3 == `F3_ADDSUB) && alt;
        add_b  = is_sub ? ~rs2 : opb;
        // Sum of the upper parts of the adder operands
        hi_sum = rs1[`ALU_WIDTH-1:`APX_LEN] + add_b[`ALU_WIDTH-1:`APX_LEN];

        // RV32I legality with funct7 as immediate data for I-type non-shifts
        supported = (funct7 == `F7_BASE) ||
                    (alt && (funct3 == `F3_ADDSUB || funct3 == `F3_SR));
        if (opcode == `OPC_OP_IMM && funct3 != `F3_SLL && funct3 != `F3_SR) begin
            supported = 1'b1;
        end
        supported = supported && (opcode == `OPC_OP || opcode == `OPC_OP_IMM);

        exp_exact = '0;
        case (funct3)
            `F3_ADDSUB: exp_exact = is_sub ? rs1 - rs2 : rs1 + opb;
            `F3_SLL:    exp_exact = rs1 << opb[`SHAMT_WIDTH-1:0];
            `F3_SLT:    exp_exact = word_t'($signed(rs1) < $signed(opb));
            `F3_SLTU:   exp_exact = word_t'(rs1 < opb);
            `F3_XOR:    exp_exact = rs1 ^ opb;
            `F3_SR:     exp_exact = alt ? word_t'($signed(rs1) >>> opb[`SHAMT_WIDTH-1:0]) :
                                          rs1 >> opb[`SHAMT_WIDTH-1:0];
            `F3_OR:     exp_exact = rs1 | opb;
            `F3_AND:    exp_exact = rs1 & opb;
        endcase

        // Adds drift only in approximate mode with an enable cleared
        exact_case = !(funct3 == `F3_ADDSUB && accuracy_control[`CSR_APX_BIT] &&
                       accuracy_control[`CSR_ER_MSB:`CSR_ER_LSB] != '1);
        // A zero low byte on one add operand never produces an error
        if (funct3 == `F3_ADDSUB && !is_sub &&
            (rs1[`APX_LEN-1:0] == '0 || opb[`APX_LEN-1:0] == '0)) begin
            exact_case = 1'b1;
        end
    end

    // --------------------------------------------------
    // Checks one cycle after the inputs
    // --------------------------------------------------
    a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(in_valid && supported))
    else begin
        $error("CHECK FAILED %s result_valid: expected %b, actual %b",
               test_name, $past(in_valid && supported), result_valid);
        fail_count++;
    end

    // No new result means the old one stays
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !result_valid |-> result == $past(result))
    else begin
        $error("CHECK FAILED %s result_hold: expected %h, actual %h",
               test_name, $past(result), result);
        fail_count++;
    end

    a_exact: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && $past(exact_case)) |-> result == $past(exp_exact))
    else begin
        $error("CHECK FAILED %s exact_result: expected %h, actual %h",
               test_name, $past(exp_exact), result);
        fail_count++;
    end

    a_approx: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !$past(exact_case)) |->
        (result[`ALU_WIDTH-1:`APX_LEN] == $past(hi_sum) ||
         result[`ALU_WIDTH-1:`APX_LEN] == $past(hi_sum) + 1'b1))
    else begin
        $error("CHECK FAILED %s approx_upper: expected %h or one more, actual %h",
               test_name, $past(hi_sum), result[`ALU_WIDTH-1:`APX_LEN]);
        fail_count++;
    end

endmodule

bind alu_top alu_chk chk_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .opcode           (opcode),
    .funct3           (funct3),
    .funct7           (funct7),
    .accuracy_control (accuracy_control),
    .rs1              (rs1),
    .rs2              (rs2),
    .immediate        (immediate),
    .result_valid     (result_valid),
    .result           (result)
);

/* rtl/alu_top.sv */
/*
 * RV32I execute-stage ALU
 * Decode, approximate adder and barrel shifter side by side, followed
 * by one registered result stage; one cycle latency
 */
module alu_top import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  word_t      accuracy_control,
    input  word_t      rs1,
    input  word_t      rs2,
    input  word_t      immediate,
    output logic       result_valid,
    output word_t      result
);

    // Decode to result stage
    word_t   operand_a;
    word_t   operand_b;
    alu_op_e alu_op;
    logic    op_valid;

    // Decode to adder
    word_t   adder_a;
    word_t   adder_b;
    logic    adder_cin;
    er_t     er;
    word_t   sum;

    // Decode to shifter
    word_t   shift_value;
    shamt_t  shift_amount;
    logic    shift_right;
    logic    shift_arith;
    word_t   shifted;

    // --------------------------------------------------
    // Combinational front end
    // --------------------------------------------------
    alu_decode decode_i (
        .opcode           (opcode),
        .funct3           (funct3),
        .funct7           (funct7),
        .accuracy_control (accuracy_control),
        .rs1              (rs1),
        .rs2              (rs2),
        .immediate        (immediate),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .alu_op           (alu_op),
        .op_valid         (op_valid),
        .adder_a          (adder_a),
        .adder_b          (adder_b),
        .adder_cin        (adder_cin),
        .er               (er),
        .shift_value      (shift_value),
        .shift_amount     (shift_amount),
        .shift_right      (shift_right),
        .shift_arith      (shift_arith)
    );

    approx_adder #(
        .WIDTH     ($bits(word_t)),
        .APX_WIDTH ($bits(er_t))
    ) adder_i (
        .a   (adder_a),
        .b   (adder_b),
        .cin (adder_cin),
        .er  (er),
        .sum (sum)
    );

    barrel_shifter shifter_i (
        .shift_value  (shift_value),
        .shift_amount (shift_amount),
        .shift_right  (shift_right),
        .shift_arith  (shift_arith),
        .shifted      (shifted)
    );

    // Registered output
    alu_result_stage result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op_valid     (op_valid),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .sum          (sum),
        .shifted      (shifted),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* rtl/alu_result_stage.sv */
/*
 * ALU result stage
 * Forms the compare and logic results, muxes them with the adder and
 * shifter outputs by operation class and registers result and strobe
 */
module alu_result_stage import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  logic    op_valid,
    input  alu_op_e alu_op,
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  word_t   sum,
    input  word_t   shifted,
    output logic    result_valid,
    output word_t   result
);

    logic  lt_s;
    logic  lt_u;
    logic  accept;
    word_t sel_value;

    // --------------------------------------------------
    // Compare results
    // --------------------------------------------------
    assign lt_s = $signed(operand_a) < $signed(operand_b);
    assign lt_u = operand_a < operand_b;

    // Result select
    always_comb begin
        case (alu_op)
            ALU_ADD:   sel_value = sum;
            ALU_SLT:   sel_value = word_t'(lt_s);
            ALU_SLTU:  sel_value = word_t'(lt_u);
            ALU_XOR:   sel_value = operand_a ^ operand_b;
            ALU_OR:    sel_value = operand_a | operand_b;
            ALU_AND:   sel_value = operand_a & operand_b;
            ALU_SHIFT: sel_value = shifted;
            default:   sel_value = '0;
        endcase
    end

    // Only a strobed, decodable instruction updates the output
    assign accept = in_valid & op_valid;

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= accept;
            // Rejected input leaves the last result in place
            if (accept) begin
                result <= sel_value;
            end
        end
    end

endmodule

/* rtl/barrel_shifter.sv */
/*
 * Barrel shifter
 * Logarithmic right shifter in five mux stages; left shifts reverse the
 * word before and after, arithmetic right shifts fill with the sign bit
 */
module barrel_shifter import alu_pkg::*; (
    input  word_t  shift_value,
    input  shamt_t shift_amount,
    input  logic   shift_right,
    input  logic   shift_arith,
    output word_t  shifted
);

    localparam int W = $bits(word_t);
    localparam int S = $bits(shamt_t);

    // Bit order reversal
    function automatic word_t flip(input word_t v);
        word_t r;
        for (int i = 0; i < W; i++) begin
            r[i] = v[W-1-i];
        end
        return r;
    endfunction

    // Stage outputs, entry 0 is the stage input
    logic [S:0][W-1:0] stg;
    logic              fill;

    // Sign fill only for SRA, zero for SRL and SLL
    assign fill = shift_right & shift_arith & shift_value[W-1];

    // Left shifts run through the right shifter mirrored
    assign stg[0] = shift_right ? shift_value : flip(shift_value);

    // --------------------------------------------------
    // Shift by 1, 2, 4, 8 and 16
    // --------------------------------------------------
    for (genvar s = 0; s < S; s++) begin : g_stage
        localparam int N = 1 << s;
        assign stg[s+1] = shift_amount[s] ? {{N{fill}}, stg[s][W-1:N]} : stg[s];
    end

    // Undo the mirror for left shifts
    assign shifted = shift_right ? stg[S] : flip(stg[S]);

endmodule

/* rtl/approx_adder.sv */
/*
 * Accuracy-controllable adder
 * Error-configurable ripple block on bits 3..0, then 4-bit carry-select
 * groups of half adder, 3-bit ripple chain and incrementer
 * Ripple cells below APX_WIDTH drop their carry logic when the enable is 0
 */
module approx_adder import alu_pkg::*; #(
    parameter int WIDTH     = $bits(word_t),
    parameter int APX_WIDTH = $bits(er_t)
) (
    input  logic [WIDTH-1:0]     a,
    input  logic [WIDTH-1:0]     b,
    input  logic                 cin,
    input  logic [APX_WIDTH-1:0] er,
    output logic [WIDTH-1:0]     sum
);

    // Groups of 4 bits, group 0 is the plain ripple block
    localparam int NGRP = WIDTH / 4;

    // Full adder cell with error enable, returns {carry, sum}
    // With en low the sum is p | ci and the carry is x & (y | ci)
    function automatic logic [1:0] ec_fa(input logic en, input logic x,
                                         input logic y, input logic ci);
        logic p;
        logic s;
        logic co;
        p  = x ^ y;
        s  = ~(en & p & ci) & (p | ci);
        co = (en & y & ci) | ((y | ci) & x);
        return {co, s};
    endfunction

    // Carry out of each group except the last one
    logic [NGRP-2:0] gcarry;

    // --------------------------------------------------
    // Bits 3..0
    // --------------------------------------------------
    logic [4:0] rc0;

    assign rc0[0] = cin;

    for (genvar k = 0; k < 4; k++) begin : g_lsb
        assign {rc0[k+1], sum[k]} = ec_fa(er[k], a[k], b[k], rc0[k]);
    end

    assign gcarry[0] = rc0[4];

    // --------------------------------------------------
    // Carry-select groups
    // --------------------------------------------------
    for (genvar g = 1; g < NGRP; g++) begin : g_grp
        localparam int B = 4 * g;

        logic [3:0] raw;    // group sum assuming carry in of 0
        logic [3:0] rc;     // carry out of each bit in the group
        logic [3:0] inc;    // raw + 1
        logic [2:0] er_g;

        // Half adder on the group's lowest bit, always exact
        assign raw[0] = a[B] ^ b[B];
        assign rc[0]  = a[B] & b[B];

        if (B < APX_WIDTH) begin : g_apx
            assign er_g = er[B+3:B+1];
        end else begin : g_exact
            assign er_g = '1;
        end

        // 3-bit ripple chain above the half adder
        for (genvar k = 1; k < 4; k++) begin : g_bit
            assign {rc[k], raw[k]} = ec_fa(er_g[k-1], a[B+k], b[B+k], rc[k-1]);
        end

        // Incrementer for the carry-in-of-1 case
        assign inc[0] = ~raw[0];
        assign inc[1] = raw[1] ^ raw[0];
        assign inc[2] = raw[2] ^ (raw[1] & raw[0]);
        assign inc[3] = raw[3] ^ (raw[2] & raw[1] & raw[0]);

        // Carry from the group below picks plain or incremented sum
        assign sum[B+3:B] = gcarry[g-1] ? inc : raw;

        // Top group carry is the adder carry-out, not needed here
        if (g < NGRP - 1) begin : g_cout
            assign gcarry[g] = gcarry[g-1] ? (rc[3] | (&raw)) : rc[3];
        end
    end

endmodule

/* rtl/alu_decode.sv */
/*
 * ALU decode
 * Checks opcode, funct3 and funct7 for a supported OP or OP_IMM
 * instruction, picks the operands and sets up the adder and shifter
 */
`include "alu_defs.svh"

module alu_decode import alu_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  word_t      accuracy_control,
    input  word_t      rs1,
    input  word_t      rs2,
    input  word_t      immediate,
    output word_t      operand_a,
    output word_t      operand_b,
    output alu_op_e    alu_op,
    output logic       op_valid,
    output word_t      adder_a,
    output word_t      adder_b,
    output logic       adder_cin,
    output er_t        er,
    output word_t      shift_value,
    output shamt_t     shift_amount,
    output logic       shift_right,
    output logic       shift_arith
);

    logic is_op;
    logic is_op_imm;
    logic f7_ok;
    logic is_sub;

    assign is_op     = (opcode == `OPC_OP);
    assign is_op_imm = (opcode == `OPC_OP_IMM);

    // Immediate replaces rs2 for the I-type forms
    assign operand_a = rs1;
    assign operand_b = is_op_imm ? immediate : rs2;

    // --------------------------------------------------
    // Legal funct7 per funct3
    // --------------------------------------------------
    always_comb begin
        f7_ok = (funct7 == `F7_BASE);
        // ADDSUB and SR use the alternate code for SUB and SRA
        if (funct3 == `F3_ADDSUB || funct3 == `F3_SR) begin
            f7_ok = f7_ok || (funct7 == `F7_ALT);
        end
        // Upper immediate bits are data except for the shift forms
        if (is_op_imm && funct3 != `F3_SLL && funct3 != `F3_SR) begin
            f7_ok = 1'b1;
        end
    end

    assign op_valid = (is_op || is_op_imm) && f7_ok;

    // Operation class from funct3
    always_comb begin
        alu_op = ALU_ADD;
        case (funct3)
            `F3_SLL:  alu_op = ALU_SHIFT;
            `F3_SLT:  alu_op = ALU_SLT;
            `F3_SLTU: alu_op = ALU_SLTU;
            `F3_XOR:  alu_op = ALU_XOR;
            `F3_SR:   alu_op = ALU_SHIFT;
            `F3_OR:   alu_op = ALU_OR;
            `F3_AND:  alu_op = ALU_AND;
            default:  alu_op = ALU_ADD;
        endcase
    end

    // --------------------------------------------------
    // Adder controls
    // --------------------------------------------------
    // SUB exists only in the register form, ADDI ignores funct7
    assign is_sub    = is_op && (funct3 == `F3_ADDSUB) && (funct7 == `F7_ALT);
    assign adder_a   = rs1;
    assign adder_b   = is_sub ? ~operand_b : operand_b;
    assign adder_cin = is_sub;

    // Approximate mode off forces every bit exact
    assign er = accuracy_control[`CSR_APX_BIT] ?
                accuracy_control[`CSR_ER_MSB:`CSR_ER_LSB] : '1;

    // Shifter controls
    assign shift_value  = rs1;
    assign shift_amount = operand_b[$bits(shamt_t)-1:0];
    assign shift_right  = (funct3 == `F3_SR);
    assign shift_arith  = shift_right && (funct7 == `F7_ALT);

endmodule

/* rtl/alu_pkg.sv */
/*
 * ALU shared types
 * Data word, shift amount, per-bit error enables and the operation
 * class passed from decode to the result stage
 */
`include "alu_defs.svh"

package alu_pkg;

    // One datapath word
    typedef logic [`ALU_WIDTH-1:0] word_t;

    // Shift distance, low bits of the second operand
    typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

    // Error enables for the approximate low bits
    // A set bit keeps that position exact
    typedef logic [`APX_LEN-1:0] er_t;

    // --------------------------------------------------
    // Operation class seen by the result mux
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,   // ADD, ADDI and SUB through the adder
        ALU_SLT   = 3'd1,
        ALU_SLTU  = 3'd2,
        ALU_XOR   = 3'd3,
        ALU_OR    = 3'd4,
        ALU_AND   = 3'd5,
        ALU_SHIFT = 3'd6    // all left and right shifts
    } alu_op_e;

endpackage

/* rtl/alu_defs.svh */
/*
 * ALU constants
 * Data and shift widths, the approximate region size, the OP and OP_IMM
 * opcodes, funct3 and funct7 codes and the accuracy CSR field positions
 */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
`define ALU_WIDTH    32
`define SHAMT_WIDTH  5
// Low bits that may be approximated, kept a multiple of 4
`define APX_LEN      8

// Register-register and register-immediate classes
`define OPC_OP       7'b01_100_11
`define OPC_OP_IMM   7'b00_100_11

// --------------------------------------------------
// funct3 codes, shared by the immediate forms
// --------------------------------------------------
`define F3_ADDSUB    3'b000
`define F3_SLL       3'b001
`define F3_SLT       3'b010
`define F3_SLTU      3'b011
`define F3_XOR       3'b100
`define F3_SR        3'b101
`define F3_OR        3'b110
`define F3_AND       3'b111

// Alternate funct7 picks SUB and SRA
`define F7_BASE      7'b000_0000
`define F7_ALT       7'b010_0000

// Accuracy CSR layout
`define CSR_APX_BIT  0
`define CSR_ER_LSB   3
`define CSR_ER_MSB   10

`endif
